//--- hdl/frontEndPkg.sv
package frontEndPkg;

    localparam int ImemBytes  = 512;  // Instruction store size
    localparam int InstrBytes = 4;    // PC step per instruction
    localparam int ImemAddrW  = $clog2(ImemBytes);

    typedef logic [31:0]          wordT;     // Instruction, address or PC
    typedef logic [1:0]           opT;       // Major opcode, bits 31:30
    typedef logic [5:0]           op3T;      // Format-3 operation, bits 24:19
    typedef logic [3:0]           aluOpT;    // ALU operation code
    typedef logic [1:0]           memSizeT;  // Access size
    typedef logic [ImemAddrW-1:0] imemAddrT; // Byte index into instruction store

    localparam wordT ResetPc  = 32'd0;
    localparam wordT ResetNpc = 32'd4;
    localparam wordT NopInstr = 32'd0;

    // Major opcodes
    localparam opT OpBranch = 2'b00;
    localparam opT OpCall   = 2'b01;
    localparam opT OpArith  = 2'b10;
    localparam opT OpMem    = 2'b11;

    localparam logic [2:0] Op2Sethi = 3'b100;  // Format-2 op2 field

    localparam op3T Op3Jmpl = 6'b111000;

    // Load and store forms
    localparam op3T Op3Ldsb = 6'b001001;
    localparam op3T Op3Ldsh = 6'b001010;
    localparam op3T Op3Ld   = 6'b000000;
    localparam op3T Op3Ldub = 6'b000001;
    localparam op3T Op3Lduh = 6'b000010;
    localparam op3T Op3Stb  = 6'b000101;
    localparam op3T Op3Sth  = 6'b000110;
    localparam op3T Op3St   = 6'b000100;

    localparam memSizeT SizeByte = 2'b00;
    localparam memSizeT SizeHalf = 2'b01;
    localparam memSizeT SizeWord = 2'b10;

    localparam aluOpT AluAdd   = 4'd0;
    localparam aluOpT AluAddx  = 4'd1;   // Add with carry
    localparam aluOpT AluSub   = 4'd2;
    localparam aluOpT AluSubx  = 4'd3;   // Subtract with carry
    localparam aluOpT AluAnd   = 4'd4;
    localparam aluOpT AluOr    = 4'd5;
    localparam aluOpT AluXor   = 4'd6;
    localparam aluOpT AluXnor  = 4'd7;
    localparam aluOpT AluAndn  = 4'd8;
    localparam aluOpT AluOrn   = 4'd9;
    localparam aluOpT AluSll   = 4'd10;
    localparam aluOpT AluSrl   = 4'd11;
    localparam aluOpT AluSra   = 4'd12;
    localparam aluOpT AluPassB = 4'd14;  // Used by SETHI

endpackage

//--- hdl/ctrlIf.sv
interface ctrlIf;

    logic                  jmpl;
    logic                  readWrite;  // High for a store
    frontEndPkg::aluOpT    aluOp;
    logic                  signExt;
    logic                  load;
    logic                  rfEnable;
    frontEndPkg::memSizeT  memSize;
    logic                  modifyCc;
    logic                  call;
    logic                  branch;
    logic                  annul;      // Bit 29 of a branch
    logic                  memEnable;

    modport decoder (
        output jmpl, readWrite, aluOp, signExt, load, rfEnable,
               memSize, modifyCc, call, branch, annul, memEnable
    );

    modport pipeline (
        input  jmpl, readWrite, aluOp, signExt, load, rfEnable,
               memSize, modifyCc, call, branch, annul, memEnable
    );

    // Redirect and annul controls seen by the fetch stage
    modport fetch (
        input  call, branch, annul
    );

endinterface

//--- hdl/instrMemory.sv
module instrMemory (
    input  logic                   Clk,
    input  logic                   wrEn,
    input  frontEndPkg::imemAddrT  wrAddr,
    input  frontEndPkg::wordT      wrData,
    input  frontEndPkg::wordT      rdAddr,
    output frontEndPkg::wordT      rdData
);

    logic [7:0] mem [frontEndPkg::ImemBytes];
    frontEndPkg::imemAddrT rdIdx;

    assign rdIdx = frontEndPkg::imemAddrT'(rdAddr);  // Low address bits only

    // Big-endian word store, most significant byte at the lowest address
    always_ff @(posedge Clk)
    begin
        if (wrEn)
        begin
            for (int i = 0; i < frontEndPkg::InstrBytes; i++)
            begin
                mem[wrAddr + frontEndPkg::imemAddrT'(i)] <=
                    wrData[8*(frontEndPkg::InstrBytes-1-i) +: 8];
            end
        end
    end

    always_comb
    begin
        rdData = '0;
        for (int i = 0; i < frontEndPkg::InstrBytes; i++)
        begin
            rdData[8*(frontEndPkg::InstrBytes-1-i) +: 8] = mem[rdIdx + frontEndPkg::imemAddrT'(i)];
        end
    end

    wrAlign: assert property (@(posedge Clk) wrEn |-> (wrAddr[1:0] == 2'b00));

endmodule

//--- hdl/fetchUnit.sv
module fetchUnit (
    input  logic               Clk,
    input  logic               rstN,
    ctrlIf.fetch               ctrl,
    input  logic               branchTaken,
    input  logic               exJmpl,
    input  frontEndPkg::wordT  jmplTarget,
    input  frontEndPkg::wordT  fetchWord,
    output frontEndPkg::wordT  pc,
    output frontEndPkg::wordT  instrId
);

    frontEndPkg::wordT nPc;
    frontEndPkg::wordT nPcNext;
    frontEndPkg::wordT pcId;        // PC of the instruction in ID
    frontEndPkg::wordT callTarget;
    frontEndPkg::wordT branchTarget;
    logic              redirectId;

    // disp30 and disp22 are word displacements
    assign callTarget   = pcId + {instrId[29:0], 2'b00};
    assign branchTarget = pcId + {{8{instrId[21]}}, instrId[21:0], 2'b00};

    assign redirectId = ctrl.call || (ctrl.branch && branchTaken);

    // JMPL in EX outranks a call or branch in ID
    always_comb
    begin
        if (exJmpl)
        begin
            nPcNext = jmplTarget;
        end
        else if (redirectId)
        begin
            nPcNext = ctrl.call ? callTarget : branchTarget;
        end
        else
        begin
            nPcNext = nPc + frontEndPkg::wordT'(frontEndPkg::InstrBytes);
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            pc      <= frontEndPkg::ResetPc;
            nPc     <= frontEndPkg::ResetNpc;
            instrId <= frontEndPkg::NopInstr;
        end
        else
        begin
            pc      <= nPc;        // One delay slot
            nPc     <= nPcNext;
            instrId <= (ctrl.branch && ctrl.annul) ? frontEndPkg::NopInstr : fetchWord;
        end
    end

    always_ff @(posedge Clk)
    begin
        pcId <= pc;
    end

    pcAlign: assert property (@(posedge Clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

//--- hdl/instrDecoder.sv
module instrDecoder (
    input  frontEndPkg::wordT  instrId,
    ctrlIf.decoder             ctrl
);

    frontEndPkg::opT  op;
    frontEndPkg::op3T op3;

    assign op  = instrId[31:30];
    assign op3 = instrId[24:19];

    always_comb
    begin
        ctrl.jmpl      = 1'b0;
        ctrl.readWrite = 1'b0;
        ctrl.aluOp     = frontEndPkg::AluAdd;
        ctrl.signExt   = 1'b0;
        ctrl.load      = 1'b0;
        ctrl.rfEnable  = 1'b0;
        ctrl.memSize   = frontEndPkg::SizeByte;
        ctrl.modifyCc  = 1'b0;
        ctrl.call      = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.annul     = 1'b0;
        ctrl.memEnable = 1'b0;

        case (op)
            frontEndPkg::OpCall:
            begin
                ctrl.call     = 1'b1;
                ctrl.rfEnable = 1'b1;  // Return address goes to r15
            end

            frontEndPkg::OpBranch:
            begin
                if (instrId[24:22] == frontEndPkg::Op2Sethi)
                begin
                    ctrl.aluOp    = frontEndPkg::AluPassB;
                    ctrl.rfEnable = 1'b1;
                end
                else if (instrId != frontEndPkg::NopInstr)  // Nop keeps every field clear
                begin
                    ctrl.branch = 1'b1;
                    ctrl.annul  = instrId[29];
                end
            end

            frontEndPkg::OpArith:
            begin
                ctrl.rfEnable = 1'b1;
                if (op3 == frontEndPkg::Op3Jmpl)
                begin
                    ctrl.jmpl = 1'b1;  // Target is rs1 plus operand
                end
                else
                begin
                    ctrl.modifyCc = op3[4];  // The cc variants
                    case (op3[3:0])
                        4'd0:    ctrl.aluOp = frontEndPkg::AluAdd;
                        4'd8:    ctrl.aluOp = frontEndPkg::AluAddx;
                        4'd4:    ctrl.aluOp = frontEndPkg::AluSub;
                        4'd12:   ctrl.aluOp = frontEndPkg::AluSubx;
                        4'd1:    ctrl.aluOp = frontEndPkg::AluAnd;
                        4'd2:    ctrl.aluOp = frontEndPkg::AluOr;
                        4'd3:    ctrl.aluOp = frontEndPkg::AluXor;
                        4'd5:    ctrl.aluOp = op3[5] ? frontEndPkg::AluSll : frontEndPkg::AluAndn;
                        4'd6:    ctrl.aluOp = op3[5] ? frontEndPkg::AluSrl : frontEndPkg::AluOrn;
                        4'd7:    ctrl.aluOp = op3[5] ? frontEndPkg::AluSra : frontEndPkg::AluXnor;
                        default: ctrl.aluOp = frontEndPkg::AluAdd;
                    endcase
                end
            end

            frontEndPkg::OpMem:
            begin
                ctrl.memEnable = 1'b1;  // Unlisted forms only enable memory
                case (op3)
                    frontEndPkg::Op3Ldsb, frontEndPkg::Op3Ldub:
                    begin
                        ctrl.load     = 1'b1;
                        ctrl.rfEnable = 1'b1;
                        ctrl.memSize  = frontEndPkg::SizeByte;
                        ctrl.signExt  = (op3 == frontEndPkg::Op3Ldsb);
                    end
                    frontEndPkg::Op3Ldsh, frontEndPkg::Op3Lduh:
                    begin
                        ctrl.load     = 1'b1;
                        ctrl.rfEnable = 1'b1;
                        ctrl.memSize  = frontEndPkg::SizeHalf;
                        ctrl.signExt  = (op3 == frontEndPkg::Op3Ldsh);
                    end
                    frontEndPkg::Op3Ld:
                    begin
                        ctrl.load     = 1'b1;
                        ctrl.rfEnable = 1'b1;
                        ctrl.memSize  = frontEndPkg::SizeWord;
                    end
                    frontEndPkg::Op3Stb:
                    begin
                        ctrl.readWrite = 1'b1;
                        ctrl.memSize   = frontEndPkg::SizeByte;
                    end
                    frontEndPkg::Op3Sth:
                    begin
                        ctrl.readWrite = 1'b1;
                        ctrl.memSize   = frontEndPkg::SizeHalf;
                    end
                    frontEndPkg::Op3St:
                    begin
                        ctrl.readWrite = 1'b1;
                        ctrl.memSize   = frontEndPkg::SizeWord;
                    end
                    default:
                    begin
                    end
                endcase
            end
        endcase
    end

    always_comb
    begin
        noLoadStore: assert (!(ctrl.load && ctrl.readWrite));
    end

endmodule

//--- hdl/ctrlPipeline.sv
module ctrlPipeline (
    input  logic                  Clk,
    input  logic                  rstN,
    ctrlIf.pipeline               ctrl,
    output frontEndPkg::aluOpT    exAluOp,
    output logic                  exModifyCc,
    output logic                  exJmpl,
    output logic                  memReadWrite,
    output frontEndPkg::memSizeT  memSize,
    output logic                  memSignExt,
    output logic                  memLoad,
    output logic                  memEnable,
    output logic                  memCall,
    output logic                  wbRfEnable
);

    // EX fields that only travel on to MEM
    logic                 exReadWrite;
    frontEndPkg::memSizeT exMemSize;
    logic                 exSignExt;
    logic                 exLoad;
    logic                 exRfEnable;
    logic                 exCall;
    logic                 exMemEnable;
    logic                 memRfEnable;

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            exAluOp     <= frontEndPkg::AluAdd;
            exModifyCc  <= 1'b0;
            exJmpl      <= 1'b0;
            exReadWrite <= 1'b0;
            exMemSize   <= frontEndPkg::SizeByte;
            exSignExt   <= 1'b0;
            exLoad      <= 1'b0;
            exRfEnable  <= 1'b0;
            exCall      <= 1'b0;
            exMemEnable <= 1'b0;
        end
        else
        begin
            exAluOp     <= ctrl.aluOp;
            exModifyCc  <= ctrl.modifyCc;
            exJmpl      <= ctrl.jmpl;
            exReadWrite <= ctrl.readWrite;
            exMemSize   <= ctrl.memSize;
            exSignExt   <= ctrl.signExt;
            exLoad      <= ctrl.load;
            exRfEnable  <= ctrl.rfEnable;
            exCall      <= ctrl.call;
            exMemEnable <= ctrl.memEnable;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            memReadWrite <= 1'b0;
            memSize      <= frontEndPkg::SizeByte;
            memSignExt   <= 1'b0;
            memLoad      <= 1'b0;
            memEnable    <= 1'b0;
            memCall      <= 1'b0;
            memRfEnable  <= 1'b0;
        end
        else
        begin
            memReadWrite <= exReadWrite;
            memSize      <= exMemSize;
            memSignExt   <= exSignExt;
            memLoad      <= exLoad;
            memEnable    <= exMemEnable;
            memCall      <= exCall;
            memRfEnable  <= exRfEnable;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            wbRfEnable <= 1'b0;
        end
        else
        begin
            wbRfEnable <= memRfEnable;
        end
    end

    memAccessEnabled: assert property (@(posedge Clk) disable iff (!rstN)
        (memReadWrite || memLoad) |-> memEnable);

endmodule

//--- hdl/frontEndTop.sv
module frontEndTop (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   imemWrEn,
    input  frontEndPkg::imemAddrT  imemWrAddr,
    input  frontEndPkg::wordT      imemWrData,
    input  logic                   branchTaken,
    input  frontEndPkg::wordT      jmplTarget,
    output frontEndPkg::wordT      pc,
    output frontEndPkg::aluOpT     exAluOp,
    output logic                   exModifyCc,
    output logic                   exJmpl,
    output logic                   memReadWrite,
    output frontEndPkg::memSizeT   memSize,
    output logic                   memSignExt,
    output logic                   memLoad,
    output logic                   memEnable,
    output logic                   memCall,
    output logic                   wbRfEnable
);

    frontEndPkg::wordT fetchWord;
    frontEndPkg::wordT instrId;

    ctrlIf ctrl ();  // Decoded control word of the ID instruction

    instrMemory uImem (
        .Clk    (Clk),
        .wrEn   (imemWrEn),
        .wrAddr (imemWrAddr),
        .wrData (imemWrData),
        .rdAddr (pc),
        .rdData (fetchWord)
    );

    fetchUnit uFetch (
        .Clk         (Clk),
        .rstN        (rstN),
        .ctrl        (ctrl.fetch),
        .branchTaken (branchTaken),
        .exJmpl      (exJmpl),
        .jmplTarget  (jmplTarget),
        .fetchWord   (fetchWord),
        .pc          (pc),
        .instrId     (instrId)
    );

    instrDecoder uDecoder (
        .instrId (instrId),
        .ctrl    (ctrl.decoder)
    );

    ctrlPipeline uPipe (
        .Clk          (Clk),
        .rstN         (rstN),
        .ctrl         (ctrl.pipeline),
        .exAluOp      (exAluOp),
        .exModifyCc   (exModifyCc),
        .exJmpl       (exJmpl),
        .memReadWrite (memReadWrite),
        .memSize      (memSize),
        .memSignExt   (memSignExt),
        .memLoad      (memLoad),
        .memEnable    (memEnable),
        .memCall      (memCall),
        .wbRfEnable   (wbRfEnable)
    );

endmodule

//--- verif/frontEndTb.sv
module frontEndTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ProgWords  = 32;    // Words loaded per test, from address 0
    localparam int CycleLimit = 3000;  // Six tests of about 60 cycles each, with wide margin

    logic                  Clk;
    logic                  rstN;
    logic                  imemWrEn;
    frontEndPkg::imemAddrT imemWrAddr;
    frontEndPkg::wordT     imemWrData;
    logic                  branchTaken;
    frontEndPkg::wordT     jmplTarget;
    frontEndPkg::wordT     pc;
    frontEndPkg::aluOpT    exAluOp;
    logic                  exModifyCc;
    logic                  exJmpl;
    logic                  memReadWrite;
    frontEndPkg::memSizeT  memSize;
    logic                  memSignExt;
    logic                  memLoad;
    logic                  memEnable;
    logic                  memCall;
    logic                  wbRfEnable;

    // Program image and the control word each instruction should decode to
    frontEndPkg::wordT    prog    [ProgWords];
    frontEndPkg::aluOpT   expAlu  [ProgWords];
    frontEndPkg::memSizeT expSize [ProgWords];
    logic                 expCc   [ProgWords];
    logic                 expRw   [ProgWords];
    logic                 expSe   [ProgWords];
    logic                 expLd   [ProgWords];
    logic                 expMe   [ProgWords];
    logic                 expRf   [ProgWords];

    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    frontEndTop DUT (
        .Clk          (Clk),
        .rstN         (rstN),
        .imemWrEn     (imemWrEn),
        .imemWrAddr   (imemWrAddr),
        .imemWrData   (imemWrData),
        .branchTaken  (branchTaken),
        .jmplTarget   (jmplTarget),
        .pc           (pc),
        .exAluOp      (exAluOp),
        .exModifyCc   (exModifyCc),
        .exJmpl       (exJmpl),
        .memReadWrite (memReadWrite),
        .memSize      (memSize),
        .memSignExt   (memSignExt),
        .memLoad      (memLoad),
        .memEnable    (memEnable),
        .memCall      (memCall),
        .wbRfEnable   (wbRfEnable)
    );

    initial Clk = 1'b0;
    always #50 Clk = ~Clk;  // 100 ns period

    always @(posedge Clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CycleLimit)
        begin
            $display("timeout: the run went past %0d cycles without finishing", CycleLimit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic checkWord(input string what, input frontEndPkg::wordT got,
                             input frontEndPkg::wordT exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkAluOp(input string what, input frontEndPkg::aluOpT got,
                              input frontEndPkg::aluOpT exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkSize(input string what, input frontEndPkg::memSizeT got,
                             input frontEndPkg::memSizeT exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("error at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("error at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Instruction encoders, register fields and immediates are random
    function automatic frontEndPkg::wordT fmt3Instr(input frontEndPkg::opT op,
                                                    input frontEndPkg::op3T op3);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [13:0] operand;  // i bit and simm13 or rs2
        rd      = 5'($urandom);
        rs1     = 5'($urandom);
        operand = 14'($urandom);
        return {op, rd, op3, rs1, operand};
    endfunction

    function automatic frontEndPkg::wordT sethiInstr();
        logic [4:0]  rd;
        logic [21:0] imm;
        rd  = 5'($urandom_range(31, 1));  // Nonzero rd keeps it apart from a nop
        imm = 22'($urandom);
        return {frontEndPkg::OpBranch, rd, frontEndPkg::Op2Sethi, imm};
    endfunction

    function automatic frontEndPkg::wordT branchInstr(input logic annul, input logic [3:0] cond,
                                                      input logic [21:0] disp);
        return {frontEndPkg::OpBranch, annul, cond, 3'b010, disp};  // Bicc
    endfunction

    function automatic frontEndPkg::wordT callInstr(input logic [29:0] disp);
        return {frontEndPkg::OpCall, disp};
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < ProgWords; i++)
        begin
            prog[i]    = frontEndPkg::NopInstr;
            expAlu[i]  = frontEndPkg::AluAdd;
            expSize[i] = frontEndPkg::SizeByte;
            expCc[i]   = 1'b0;
            expRw[i]   = 1'b0;
            expSe[i]   = 1'b0;
            expLd[i]   = 1'b0;
            expMe[i]   = 1'b0;
            expRf[i]   = 1'b0;
        end
    endtask

    task automatic addAlu(input int idx, input frontEndPkg::op3T op3,
                          input frontEndPkg::aluOpT alu, input logic cc);
        prog[idx]   = fmt3Instr(frontEndPkg::OpArith, op3);
        expAlu[idx] = alu;
        expCc[idx]  = cc;
        expRf[idx]  = 1'b1;
    endtask

    task automatic addMem(input int idx, input frontEndPkg::op3T op3,
                          input frontEndPkg::memSizeT size, input logic se, input logic ld);
        prog[idx]    = fmt3Instr(frontEndPkg::OpMem, op3);
        expSize[idx] = size;
        expSe[idx]   = se;
        expLd[idx]   = ld;
        expRw[idx]   = !ld;
        expMe[idx]   = 1'b1;
        expRf[idx]   = ld;
    endtask

    // Reset stays low while the program loads, one word per cycle
    task automatic loadProgram();
        for (int i = 0; i < ProgWords; i++)
        begin
            @(posedge Clk);
            rstN        <= 1'b0;
            branchTaken <= 1'b0;
            imemWrEn    <= 1'b1;
            imemWrAddr  <= frontEndPkg::imemAddrT'(4 * i);
            imemWrData  <= prog[i];
        end
        @(posedge Clk);
        imemWrEn <= 1'b0;
        rstN     <= 1'b1;
    endtask

    // Instruction k is in ID after edge k+1, EX after k+2, MEM after k+3, WB after k+4
    task automatic checkPipeline(input int e);
        int   exIdx;
        int   memIdx;
        int   wbIdx;
        logic exOk;
        logic memOk;
        logic wbOk;
        exIdx  = e - 2;
        memIdx = e - 3;
        wbIdx  = e - 4;
        exOk   = (exIdx >= 0) && (exIdx < ProgWords);
        memOk  = (memIdx >= 0) && (memIdx < ProgWords);
        wbOk   = (wbIdx >= 0) && (wbIdx < ProgWords);
        checkAluOp("exAluOp", exAluOp, exOk ? expAlu[exIdx] : frontEndPkg::AluAdd);
        checkBit("exModifyCc", exModifyCc, exOk && expCc[exIdx]);
        checkBit("exJmpl", exJmpl, 1'b0);
        checkBit("memReadWrite", memReadWrite, memOk && expRw[memIdx]);
        checkSize("memSize", memSize, memOk ? expSize[memIdx] : frontEndPkg::SizeByte);
        checkBit("memSignExt", memSignExt, memOk && expSe[memIdx]);
        checkBit("memLoad", memLoad, memOk && expLd[memIdx]);
        checkBit("memEnable", memEnable, memOk && expMe[memIdx]);
        checkBit("memCall", memCall, 1'b0);
        checkBit("wbRfEnable", wbRfEnable, wbOk && expRf[wbIdx]);
    endtask

    // Straight-line program, pc steps by 4 from the reset value
    task automatic runStraight(input int edges);
        @(negedge Clk);
        checkWord("pc in reset", pc, frontEndPkg::ResetPc);
        checkPipeline(0);
        for (int e = 1; e <= edges; e++)
        begin
            @(posedge Clk);
            @(negedge Clk);
            checkWord("pc", pc, frontEndPkg::wordT'(4 * e));
            checkPipeline(e);
        end
    endtask

    task automatic testReset();
        clearProgram();
        loadProgram();
        runStraight(12);
    endtask

    task automatic testAluDecode();
        clearProgram();
        addAlu(0, 6'b000000, frontEndPkg::AluAdd, 1'b0);
        addAlu(1, 6'b010000, frontEndPkg::AluAdd, 1'b1);   // addcc
        addAlu(2, 6'b001000, frontEndPkg::AluAddx, 1'b0);
        addAlu(3, 6'b000100, frontEndPkg::AluSub, 1'b0);
        addAlu(4, 6'b010100, frontEndPkg::AluSub, 1'b1);   // subcc
        addAlu(5, 6'b001100, frontEndPkg::AluSubx, 1'b0);
        addAlu(6, 6'b000001, frontEndPkg::AluAnd, 1'b0);
        addAlu(7, 6'b010001, frontEndPkg::AluAnd, 1'b1);   // andcc
        addAlu(8, 6'b000010, frontEndPkg::AluOr, 1'b0);
        addAlu(9, 6'b000011, frontEndPkg::AluXor, 1'b0);
        addAlu(10, 6'b000101, frontEndPkg::AluAndn, 1'b0);
        addAlu(11, 6'b000110, frontEndPkg::AluOrn, 1'b0);
        addAlu(12, 6'b000111, frontEndPkg::AluXnor, 1'b0);
        addAlu(13, 6'b100101, frontEndPkg::AluSll, 1'b0);
        addAlu(14, 6'b100110, frontEndPkg::AluSrl, 1'b0);
        addAlu(15, 6'b100111, frontEndPkg::AluSra, 1'b0);
        addAlu(16, 6'b001001, frontEndPkg::AluAdd, 1'b0);  // Unlisted code
        prog[17]   = sethiInstr();
        expAlu[17] = frontEndPkg::AluPassB;
        expRf[17]  = 1'b1;
        loadProgram();
        runStraight(24);
    endtask

    task automatic testLoadStore();
        clearProgram();
        addMem(0, frontEndPkg::Op3Ldsb, frontEndPkg::SizeByte, 1'b1, 1'b1);
        addMem(1, frontEndPkg::Op3Ldsh, frontEndPkg::SizeHalf, 1'b1, 1'b1);
        addMem(2, frontEndPkg::Op3Ld, frontEndPkg::SizeWord, 1'b0, 1'b1);
        addMem(3, frontEndPkg::Op3Ldub, frontEndPkg::SizeByte, 1'b0, 1'b1);
        addMem(4, frontEndPkg::Op3Lduh, frontEndPkg::SizeHalf, 1'b0, 1'b1);
        addMem(5, frontEndPkg::Op3Stb, frontEndPkg::SizeByte, 1'b0, 1'b0);
        addMem(6, frontEndPkg::Op3Sth, frontEndPkg::SizeHalf, 1'b0, 1'b0);
        addMem(7, frontEndPkg::Op3St, frontEndPkg::SizeWord, 1'b0, 1'b0);
        loadProgram();
        runStraight(14);
    endtask

    task automatic testCallBranch();
        frontEndPkg::wordT expPc [12];
        clearProgram();
        prog[0]  = callInstr(30'd8);                      // 0 to 32
        prog[8]  = branchInstr(1'b0, 4'b1000, 22'd4);     // 32 to 48, taken
        prog[12] = branchInstr(1'b0, 4'b1001, 22'd4);     // 48, not taken
        prog[14] = branchInstr(1'b0, 4'b1000, 22'(-12));  // 56 back to 8
        expPc = '{32'd4, 32'd8, 32'd32, 32'd36, 32'd40, 32'd48,
                  32'd52, 32'd56, 32'd60, 32'd64, 32'd8, 32'd12};
        loadProgram();
        for (int e = 1; e <= 12; e++)
        begin
            @(posedge Clk);
            branchTaken <= (e == 4) || (e == 9);  // Branches at 32 and 56 are in ID
            @(negedge Clk);
            checkWord("pc", pc, expPc[e-1]);
            checkBit("memCall", memCall, e == 3);
        end
    endtask

    task automatic testAnnul();
        frontEndPkg::wordT expPc [8];
        clearProgram();
        prog[0] = branchInstr(1'b1, 4'b1000, 22'd4);  // Annulling branch to 16
        prog[1] = fmt3Instr(frontEndPkg::OpMem, frontEndPkg::Op3St);
        prog[4] = branchInstr(1'b0, 4'b1001, 22'd4);  // Not taken, slot runs
        prog[5] = fmt3Instr(frontEndPkg::OpMem, frontEndPkg::Op3St);
        expPc = '{32'd4, 32'd8, 32'd16, 32'd20, 32'd24, 32'd28, 32'd32, 32'd36};
        loadProgram();
        for (int e = 1; e <= 8; e++)
        begin
            @(posedge Clk);
            branchTaken <= (e == 1);
            @(negedge Clk);
            checkWord("pc", pc, expPc[e-1]);
            checkBit("memEnable", memEnable, e == 7);
            checkBit("memReadWrite", memReadWrite, e == 7);
            checkSize("memSize", memSize, (e == 7) ? frontEndPkg::SizeWord : frontEndPkg::SizeByte);
            checkBit("memLoad", memLoad, 1'b0);
            checkBit("wbRfEnable", wbRfEnable, 1'b0);
        end
    endtask

    task automatic testJmpl();
        frontEndPkg::wordT expPc [6];
        clearProgram();
        prog[0] = fmt3Instr(frontEndPkg::OpArith, frontEndPkg::Op3Jmpl);
        prog[1] = callInstr(30'd8);  // In ID while JMPL is in EX
        expPc = '{32'd4, 32'd8, 32'd12, 32'd64, 32'd68, 32'd72};
        loadProgram();
        jmplTarget <= 32'd64;
        for (int e = 1; e <= 6; e++)
        begin
            @(posedge Clk);
            @(negedge Clk);
            checkWord("pc", pc, expPc[e-1]);
            checkBit("exJmpl", exJmpl, e == 2);
            checkBit("memCall", memCall, e == 4);
        end
    endtask

    initial
    begin
        void'($urandom(32'ha184));
        rstN        = 1'b0;
        imemWrEn    = 1'b0;
        imemWrAddr  = '0;
        imemWrData  = '0;
        branchTaken = 1'b0;
        jmplTarget  = '0;
        testReset();
        testAluDecode();
        testLoadStore();
        testCallBranch();
        testAnnul();
        testJmpl();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/frontEndPkg.sv
hdl/ctrlIf.sv
hdl/instrMemory.sv
hdl/fetchUnit.sv
hdl/instrDecoder.sv
hdl/ctrlPipeline.sv
hdl/frontEndTop.sv
verif/frontEndTb.sv

//--- run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module frontEndTb -Mdir obj_dir -o frontEndSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/frontEndSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
